// File: dv/cache_tb.sv
/*
  Testbench for the write-back data cache. Drives processor accesses,
  keeps a shadow byte memory and checks loads, hit timing and write-backs.
*/
`timescale 1ns/1ps

module cache_tb;
  import cache_geometry_pkg::*;
  import mem_op_pkg::*;

  // ack wait bound in cycles
  localparam int wait_limit = 4000;

  logic clk;
  logic reset;
  logic req;
  cpu_request_t request;
  logic ack;
  logic [63:0] load_data;
  logic bus_respcyc;
  logic bus_respack;
  logic [63:0] bus_resp;
  bus_tag_t bus_resptag;
  logic bus_reqcyc;
  logic bus_reqack;
  logic [63:0] bus_req;
  bus_tag_t bus_reqtag;
  logic hold_req;
  logic hold_resp;
  logic random_holds;
  int wb_count;
  logic [63:0] wb_address;
  cache_line_t wb_line;
  int seen_wb;
  int errors;
  int checks;
  // bytes written by stores, keyed by byte address
  logic [7:0] shadow [logic [63:0]];
  mem_op_t load_ops [7] = '{LD, LW, LH, LB, LWU, LHU, LBU};
  mem_op_t store_ops [4] = '{SD, SW, SH, SB};

  cache_top #(
    .ways(4),
    .sets(32)
  ) cache_top_i (
    .clk(clk),
    .reset(reset),
    .req(req),
    .request(request),
    .ack(ack),
    .load_data(load_data),
    .bus_respcyc(bus_respcyc),
    .bus_respack(bus_respack),
    .bus_resp(bus_resp),
    .bus_resptag(bus_resptag),
    .bus_reqcyc(bus_reqcyc),
    .bus_reqack(bus_reqack),
    .bus_req(bus_req),
    .bus_reqtag(bus_reqtag)
  );

  mem_model mem_model_i (
    .clk(clk),
    .reset(reset),
    .hold_req(hold_req),
    .hold_resp(hold_resp),
    .bus_reqcyc(bus_reqcyc),
    .bus_reqack(bus_reqack),
    .bus_req(bus_req),
    .bus_reqtag(bus_reqtag),
    .bus_respcyc(bus_respcyc),
    .bus_respack(bus_respack),
    .bus_resp(bus_resp),
    .bus_resptag(bus_resptag),
    .wb_count(wb_count),
    .wb_address(wb_address),
    .wb_line(wb_line)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // same fill as the memory model, per aligned double word
  function automatic logic [63:0] backing_value(input logic [63:0] a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
  endfunction

  function automatic logic [7:0] shadow_byte(input logic [63:0] a);
    logic [63:0] word;
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    word = backing_value({a[63:3], 3'b000});
    // little endian inside the double word
    return word[8 * a[2:0] +: 8];
  endfunction

  function automatic int op_size(input mem_op_t op);
    case (op)
      LD, SD: return 8;
      LW, LWU, SW: return 4;
      LH, LHU, SH: return 2;
      default: return 1;
    endcase
  endfunction

  function automatic logic is_load(input mem_op_t op);
    return op inside {LD, LW, LH, LB, LWU, LHU, LBU};
  endfunction

  // natural alignment for the access size
  function automatic logic [63:0] align(input logic [63:0] a, input mem_op_t op);
    return a & ~64'(op_size(op) - 1);
  endfunction

  function automatic logic [63:0] expected_load(input logic [63:0] a, input mem_op_t op);
    logic [63:0] raw;
    raw = '0;
    for (int i = 0; i < op_size(op); i++) begin
      raw[8 * i +: 8] = shadow_byte(a + i);
    end
    case (op)
      LW: return {{32{raw[31]}}, raw[31:0]};
      LH: return {{48{raw[15]}}, raw[15:0]};
      LB: return {{56{raw[7]}}, raw[7:0]};
      // LD and the unsigned forms are already zero above the element
      default: return raw;
    endcase
  endfunction

  task automatic apply_store(input logic [63:0] a, input mem_op_t op, input logic [63:0] data);
    for (int i = 0; i < op_size(op); i++) begin
      shadow[a + i] = data[8 * i +: 8];
    end
  endtask

  task automatic finish_run();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  task automatic abort_run(input string reason);
    errors++;
    $display("%s", reason);
    finish_run();
  endtask

  // a finished write-back must carry the shadow line
  task automatic check_writeback();
    cache_line_t expected;
    if (wb_count != seen_wb) begin
      seen_wb = wb_count;
      for (int i = 0; i < line_bytes; i++) begin
        expected.bytes[i] = shadow_byte(wb_address + i);
      end
      checks++;
      assert (wb_line === expected) else begin
        errors++;
        $display("FAILED wb_line at %h: got %h expected %h", wb_address, wb_line, expected);
      end
    end
  endtask

  // one cycle, ending on a falling edge
  task automatic step();
    @(negedge clk);
    if (random_holds) begin
      hold_req = ($urandom % 3) == 0;
      hold_resp = ($urandom % 3) == 0;
    end
    check_writeback();
  endtask

  // full four-phase access; latency counts cycles after req is first sampled
  task automatic access(input logic [63:0] a, input mem_op_t op, input logic [63:0] data,
                        output int latency, output logic used_bus);
    int waited;
    int linger;
    logic [63:0] expected;
    waited = 0;
    used_bus = 1'b0;
    expected = expected_load(a, op);
    request.address = a;
    request.op = op;
    request.store_data = data;
    req = 1'b1;
    while (!ack && waited < wait_limit) begin
      step();
      waited++;
      if (bus_reqcyc) begin
        used_bus = 1'b1;
      end
    end
    if (!ack) begin
      abort_run("ack never rose for a processor access");
    end else begin
      latency = waited - 1;
      if (is_load(op)) begin
        checks++;
        assert (load_data === expected) else begin
          errors++;
          $display("FAILED load_data (%s at %h): got %h expected %h",
                   op.name(), a, load_data, expected);
        end
      end else begin
        apply_store(a, op, data);
      end
      // a held req keeps ack up through the release state
      linger = random_holds ? int'($urandom % 3) : 0;
      for (int i = 0; i < linger; i++) begin
        step();
        checks++;
        assert (ack === 1'b1) else begin
          errors++;
          $display("FAILED ack while req held: got %h expected %h", ack, 1'b1);
        end
      end
      req = 1'b0;
      step();
      checks++;
      assert (ack === 1'b0) else begin
        errors++;
        $display("FAILED ack one cycle after req fell: got %h expected %h", ack, 1'b0);
      end
    end
  endtask

  initial begin
    logic [63:0] address;
    int latency;
    logic used_bus;
    int wb_before;
    mem_op_t op;
    void'($urandom(37751));
    reset = 1'b0;
    req = 1'b0;
    request = '0;
    hold_req = 1'b0;
    hold_resp = 1'b0;
    random_holds = 1'b0;
    seen_wb = 0;
    errors = 0;
    checks = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b1;

    // idle after reset, nothing moves
    for (int i = 0; i < 20; i++) begin
      step();
      checks++;
      assert (ack === 1'b0 && bus_reqcyc === 1'b0 && bus_respack === 1'b0) else begin
        errors++;
        $display("FAILED ack/bus_reqcyc/bus_respack: got %h/%h/%h expected 0/0/0",
                 ack, bus_reqcyc, bus_respack);
      end
    end

    // each load form misses once on its own set, then hits
    for (int k = 0; k < 7; k++) begin
      address = align(64'h0004_0000 + k * 64 + 45, load_ops[k]);
      access(address, load_ops[k], '0, latency, used_bus);
      checks++;
      assert (used_bus) else begin
        errors++;
        $display("a load miss completed without any bus read");
      end
      access(address, load_ops[k], '0, latency, used_bus);
      checks++;
      assert (latency == 2 && !used_bus) else begin
        errors++;
        $display("FAILED hit latency: got %h expected %h, bus_reqcyc seen %h",
                 latency, 2, used_bus);
      end
    end

    // stores on a cached line and on a fresh one, then the dword and its neighbour
    for (int l = 0; l < 2; l++) begin
      for (int k = 0; k < 4; k++) begin
        address = align(64'h0004_0000 + l * 7 * 64 + ($urandom % 64), store_ops[k]);
        access(address, store_ops[k], {$urandom, $urandom}, latency, used_bus);
        access(address & ~64'h7, LD, '0, latency, used_bus);
        access((address & ~64'h7) ^ 64'h8, LD, '0, latency, used_bus);
      end
    end

    // five dirty lines in set 20 of a four way cache
    wb_before = wb_count;
    for (int k = 0; k < 5; k++) begin
      address = 64'h0010_0500 + k * 2048;
      access(address + 8 * k, SD, {$urandom, $urandom}, latency, used_bus);
      access(address + 3, SB, {$urandom, $urandom}, latency, used_bus);
    end
    checks++;
    assert (wb_count > wb_before) else begin
      errors++;
      $display("five lines in one set caused no write-back");
    end
    for (int k = 0; k < 5; k++) begin
      address = 64'h0010_0500 + k * 2048;
      access(address + 8 * k, LD, '0, latency, used_bus);
      access(address + 3, LBU, '0, latency, used_bus);
    end

    // random mix over 6 tags x 4 sets with bus back-pressure
    random_holds = 1'b1;
    for (int n = 0; n < 300; n++) begin
      op = mem_op_t'(4'($urandom % 11));
      address = 64'h0020_0000 + 64'($urandom % 6) * 2048 + 64'($urandom % 4) * 64
                + 64'($urandom % 64);
      access(align(address, op), op, {$urandom, $urandom}, latency, used_bus);
    end
    random_holds = 1'b0;
    hold_req = 1'b0;
    hold_resp = 1'b0;
    finish_run();
  end

endmodule

// File: dv/mem_model.sv
/*
  Memory bus responder for the cache testbench. Backs a sparse memory,
  acks request beats, returns refill beats and exposes the last write-back.
*/
`timescale 1ns/1ps

module mem_model (
  input  logic clk,
  input  logic reset,
  input  logic hold_req,
  input  logic hold_resp,
  input  logic bus_reqcyc,
  output logic bus_reqack,
  input  logic [63:0] bus_req,
  input  mem_op_pkg::bus_tag_t bus_reqtag,
  output logic bus_respcyc,
  input  logic bus_respack,
  output logic [63:0] bus_resp,
  output mem_op_pkg::bus_tag_t bus_resptag,
  output int wb_count,
  output logic [63:0] wb_address,
  output cache_geometry_pkg::cache_line_t wb_line
);
  import cache_geometry_pkg::*;
  import mem_op_pkg::*;

  // written double words, keyed by byte address
  logic [63:0] backing [logic [63:0]];
  // beats taken in the current request, address beat included
  logic [3:0] req_beats;
  logic [63:0] line_address;
  logic [3:0] resp_left;
  logic [2:0] resp_index;

  // untouched memory reads back a pattern of its whole address
  function automatic logic [63:0] pattern(input logic [63:0] a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
  endfunction

  function automatic logic [63:0] read_dword(input logic [63:0] a);
    if (backing.exists(a)) begin
      return backing[a];
    end
    return pattern(a);
  endfunction

  always @(posedge clk) begin
    if (!reset) begin
      bus_reqack <= 1'b0;
      bus_respcyc <= 1'b0;
      bus_resp <= '0;
      bus_resptag <= tag_none;
      req_beats <= '0;
      line_address <= '0;
      resp_left <= '0;
      resp_index <= '0;
      wb_count <= 0;
      wb_address <= '0;
      wb_line <= '0;
    end else begin
      bus_reqack <= 1'b0;
      if (!bus_reqcyc) begin
        req_beats <= '0;
      end else if (!bus_reqack && !hold_req) begin
        // one ack pulse per beat, a gap cycle between pulses
        bus_reqack <= 1'b1;
        req_beats <= req_beats + 1'b1;
        if (req_beats == 0) begin
          line_address <= bus_req;
          if (bus_reqtag == tag_read) begin
            resp_left <= 4'd8;
            resp_index <= '0;
          end else begin
            wb_address <= bus_req;
          end
        end else begin
          // write beats, ascending from the line address
          backing[line_address + {req_beats - 1'b1, 3'b000}] = bus_req;
          wb_line.dwords[req_beats - 1'b1] <= bus_req;
          if (req_beats == 4'd8) begin
            wb_count <= wb_count + 1;
          end
        end
      end
      // refill beat holds until respack is seen
      if (bus_respcyc && bus_respack) begin
        bus_respcyc <= 1'b0;
        bus_resptag <= tag_none;
        resp_left <= resp_left - 1'b1;
        resp_index <= resp_index + 1'b1;
      end else if (!bus_respcyc && resp_left != 0 && !hold_resp) begin
        bus_respcyc <= 1'b1;
        bus_resptag <= tag_read;
        bus_resp <= read_dword(line_address + {resp_index, 3'b000});
      end
    end
  end

endmodule

// File: flist.f
source/cache_geometry_pkg.sv
source/mem_op_pkg.sv
source/cache_ways.sv
source/line_access.sv
source/miss_controller.sv
source/bus_port.sv
source/cache_top.sv
dv/mem_model.sv
dv/cache_tb.sv

// File: source/bus_port.sv
/*
  Memory bus engine. Sends the address beat of a read or a write,
  then the eight write beats, and gathers eight refill beats into a line.
*/
`timescale 1ns/1ps

module bus_port (
  input  logic clk,
  input  logic reset,
  input  logic start_read,
  input  logic start_write,
  input  logic [cache_geometry_pkg::address_bits-1:0] address,
  input  cache_geometry_pkg::cache_line_t line_in,
  input  logic [cache_geometry_pkg::address_bits-1:0] victim_address,
  output cache_geometry_pkg::cache_line_t fill_line,
  output logic done,
  output logic bus_reqcyc,
  input  logic bus_reqack,
  output logic [cache_geometry_pkg::beat_bits-1:0] bus_req,
  output mem_op_pkg::bus_tag_t bus_reqtag,
  input  logic bus_respcyc,
  output logic bus_respack,
  input  logic [cache_geometry_pkg::beat_bits-1:0] bus_resp,
  input  mem_op_pkg::bus_tag_t bus_resptag
);
  import cache_geometry_pkg::*;
  import mem_op_pkg::*;

  localparam int count_bits = $clog2(beats_per_line + 1);
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_send = 2'd1;
  localparam logic [1:0] st_recv = 2'd2;

  logic [1:0] state;
  logic writing;
  logic [count_bits-1:0] sent;
  logic [count_bits-1:0] received;
  logic send_beat;
  logic take_beat;
  cache_line_t out_line;

  // another write beat follows this ack
  assign send_beat = (state == st_send) && bus_reqack && writing && (sent < beats_per_line);
  // one response beat per respack pulse
  assign take_beat = (state == st_recv) && bus_respcyc && !bus_respack;

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= st_idle;
      writing <= 1'b0;
      sent <= '0;
      received <= '0;
      bus_reqcyc <= 1'b0;
      bus_reqtag <= tag_none;
      bus_respack <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      bus_respack <= 1'b0;
      case (state)
        st_idle: begin
          if (start_write || start_read) begin
            state <= st_send;
            writing <= start_write;
            sent <= '0;
            received <= '0;
            bus_reqcyc <= 1'b1;
            bus_reqtag <= start_write ? tag_write : tag_read;
          end
        end
        st_send: begin
          if (send_beat) begin
            sent <= sent + 1'b1;
          end else if (bus_reqack) begin
            bus_reqcyc <= 1'b0;
            bus_reqtag <= tag_none;
            // a write ends here, a read waits for its data
            done <= writing;
            state <= writing ? st_idle : st_recv;
          end
        end
        st_recv: begin
          if (take_beat) begin
            bus_respack <= 1'b1;
            if (bus_resptag == tag_read) begin
              received <= received + 1'b1;
              if (received == beats_per_line - 1) begin
                done <= 1'b1;
                state <= st_idle;
              end
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // beat data and line shift registers
  always_ff @(posedge clk) begin
    if (state == st_idle && start_write) begin
      bus_req <= victim_address;
      out_line <= line_in;
    end else if (state == st_idle && start_read) begin
      bus_req <= {address[address_bits-1:offset_bits], {offset_bits{1'b0}}};
    end else if (send_beat) begin
      bus_req <= out_line.dwords[0];
      out_line.dwords <= {{beat_bits{1'b0}}, out_line.dwords[beats_per_line-1:1]};
    end
    // beats arrive ascending, shift in from the top
    if (take_beat && bus_resptag == tag_read) begin
      fill_line.dwords <= {bus_resp, fill_line.dwords[beats_per_line-1:1]};
    end
  end

endmodule

// File: source/cache_geometry_pkg.sv
/*
  Cache line geometry shared by the cache RTL and the testbench.
  A line is 64 bytes and moves over the bus as eight 64-bit beats.
*/
package cache_geometry_pkg;

  // bytes held by one cache line
  localparam int line_bytes = 64;

  // width of one bus beat and of a processor double word
  localparam int beat_bits = 64;

  // beats needed to move one line
  localparam int beats_per_line = line_bytes * 8 / beat_bits;

  // byte offset inside a line
  localparam int offset_bits = $clog2(line_bytes);

  // full byte address
  localparam int address_bits = 64;

  // one line, read through whichever element size the access needs
  typedef union packed {
    // double words, element 0 at the lowest address
    logic [beats_per_line-1:0][beat_bits-1:0] dwords;
    // words
    logic [2*beats_per_line-1:0][31:0] words;
    // half words
    logic [4*beats_per_line-1:0][15:0] halves;
    // single bytes
    logic [line_bytes-1:0][7:0] bytes;
  } cache_line_t;

endpackage

// File: source/cache_top.sv
/*
  Write-back data cache top level. Connects the way storage, line access,
  control FSM and bus engine, and passes ways and sets down.
*/
`timescale 1ns/1ps

module cache_top #(
  parameter int ways = 4,
  parameter int sets = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic req,
  input  mem_op_pkg::cpu_request_t request,
  output logic ack,
  output logic [cache_geometry_pkg::beat_bits-1:0] load_data,
  input  logic bus_respcyc,
  output logic bus_respack,
  input  logic [cache_geometry_pkg::beat_bits-1:0] bus_resp,
  input  mem_op_pkg::bus_tag_t bus_resptag,
  output logic bus_reqcyc,
  input  logic bus_reqack,
  output logic [cache_geometry_pkg::beat_bits-1:0] bus_req,
  output mem_op_pkg::bus_tag_t bus_reqtag
);
  import cache_geometry_pkg::*;

  logic lookup;
  logic write_line;
  logic dirty_in;
  logic hit;
  logic victim_dirty;
  logic start_read;
  logic start_write;
  logic bus_done;
  logic [address_bits-1:0] victim_tag_address;
  cache_line_t way_line;
  cache_line_t merged_line;
  cache_line_t fill_line;
  cache_line_t write_data;

  // dirty writes come from a store merge, clean ones from a refill
  assign write_data = dirty_in ? merged_line : fill_line;

  cache_ways #(
    .ways(ways),
    .sets(sets)
  ) cache_ways_i (
    .clk(clk),
    .reset(reset),
    .lookup(lookup),
    .address(request.address),
    .write_line(write_line),
    .line_in(write_data),
    .dirty_in(dirty_in),
    .hit(hit),
    .victim_dirty(victim_dirty),
    .victim_tag_address(victim_tag_address),
    .line_out(way_line)
  );

  line_access line_access_i (
    .address(request.address),
    .op(request.op),
    .store_data(request.store_data),
    .line_in(way_line),
    .load_data(load_data),
    .merged_line(merged_line)
  );

  miss_controller #(
    .ways(ways),
    .sets(sets)
  ) miss_controller_i (
    .clk(clk),
    .reset(reset),
    .req(req),
    .request(request),
    .ack(ack),
    .lookup(lookup),
    .write_line(write_line),
    .dirty_in(dirty_in),
    .hit(hit),
    .victim_dirty(victim_dirty),
    .start_read(start_read),
    .start_write(start_write),
    .bus_done(bus_done)
  );

  // victim line goes out on write-back
  bus_port bus_port_i (
    .clk(clk),
    .reset(reset),
    .start_read(start_read),
    .start_write(start_write),
    .address(request.address),
    .line_in(way_line),
    .victim_address(victim_tag_address),
    .fill_line(fill_line),
    .done(bus_done),
    .bus_reqcyc(bus_reqcyc),
    .bus_reqack(bus_reqack),
    .bus_req(bus_req),
    .bus_reqtag(bus_reqtag),
    .bus_respcyc(bus_respcyc),
    .bus_respack(bus_respack),
    .bus_resp(bus_resp),
    .bus_resptag(bus_resptag)
  );

endmodule

// File: source/cache_ways.sv
/*
  Tag, valid, dirty and line storage for every way of the data cache.
  A lookup registers hit or victim information, a write fills the remembered way.
*/
`timescale 1ns/1ps

module cache_ways #(
  parameter int ways = 4,
  parameter int sets = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic lookup,
  input  logic [cache_geometry_pkg::address_bits-1:0] address,
  input  logic write_line,
  input  cache_geometry_pkg::cache_line_t line_in,
  input  logic dirty_in,
  output logic hit,
  output logic victim_dirty,
  output logic [cache_geometry_pkg::address_bits-1:0] victim_tag_address,
  output cache_geometry_pkg::cache_line_t line_out
);
  import cache_geometry_pkg::*;

  localparam int index_bits = $clog2(sets);
  localparam int tag_bits = address_bits - index_bits - offset_bits;
  localparam int way_bits = (ways > 1) ? $clog2(ways) : 1;

  logic [ways-1:0] valid_mem [sets];
  logic [ways-1:0] dirty_mem [sets];
  logic [tag_bits-1:0] tag_mem [sets][ways];
  cache_line_t data_mem [sets][ways];

  logic [index_bits-1:0] index;
  logic [tag_bits-1:0] tag;
  logic match_any;
  logic [way_bits-1:0] match_way;
  logic [way_bits-1:0] victim_way;
  logic [way_bits-1:0] pick;
  logic [way_bits-1:0] way_sel;
  logic [7:0] lfsr;

  assign index = address[offset_bits +: index_bits];
  assign tag = address[address_bits-1 -: tag_bits];

  // tag compare across all ways of the set
  always_comb begin
    match_any = 1'b0;
    match_way = '0;
    for (int i = 0; i < ways; i++) begin
      if (valid_mem[index][i] && tag_mem[index][i] == tag) begin
        match_any = 1'b1;
        match_way = way_bits'(i);
      end
    end
  end

  // lowest invalid way wins, else the lfsr picks
  always_comb begin
    victim_way = way_bits'(lfsr % ways);
    for (int i = ways - 1; i >= 0; i--) begin
      if (!valid_mem[index][i]) begin
        victim_way = way_bits'(i);
      end
    end
  end

  assign pick = match_any ? match_way : victim_way;

  always_ff @(posedge clk) begin
    if (!reset) begin
      hit <= 1'b0;
      victim_dirty <= 1'b0;
      way_sel <= '0;
      lfsr <= 8'hb5;
      for (int s = 0; s < sets; s++) begin
        valid_mem[s] <= '0;
        dirty_mem[s] <= '0;
      end
    end else begin
      // x^8 + x^6 + x^5 + x^4 + 1
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      if (lookup) begin
        hit <= match_any;
        way_sel <= pick;
        victim_dirty <= valid_mem[index][pick] && dirty_mem[index][pick];
      end
      if (write_line) begin
        valid_mem[index][way_sel] <= 1'b1;
        dirty_mem[index][way_sel] <= dirty_in;
      end
    end
  end

  // line and tag storage
  always_ff @(posedge clk) begin
    if (lookup) begin
      line_out <= data_mem[index][pick];
      // line address the victim came from
      victim_tag_address <= {tag_mem[index][pick], index, {offset_bits{1'b0}}};
    end
    if (write_line) begin
      tag_mem[index][way_sel] <= tag;
      data_mem[index][way_sel] <= line_in;
    end
  end

endmodule

// File: source/line_access.sv
/*
  Combinational load extraction and store merge for one cache line.
  Sits between the way storage and the processor side.
*/
`timescale 1ns/1ps

module line_access (
  input  logic [cache_geometry_pkg::address_bits-1:0] address,
  input  mem_op_pkg::mem_op_t op,
  input  logic [cache_geometry_pkg::beat_bits-1:0] store_data,
  input  cache_geometry_pkg::cache_line_t line_in,
  output logic [cache_geometry_pkg::beat_bits-1:0] load_data,
  output cache_geometry_pkg::cache_line_t merged_line
);
  import cache_geometry_pkg::*;
  import mem_op_pkg::*;

  logic [offset_bits-1:0] offset;
  logic [beat_bits-1:0] one_dword;
  logic [31:0] one_word;
  logic [15:0] one_half;
  logic [7:0] one_byte;

  assign offset = address[offset_bits-1:0];

  // element at the offset, one per size
  assign one_dword = line_in.dwords[offset[offset_bits-1:3]];
  assign one_word = line_in.words[offset[offset_bits-1:2]];
  assign one_half = line_in.halves[offset[offset_bits-1:1]];
  assign one_byte = line_in.bytes[offset];

  always_comb begin
    case (op)
      LD: load_data = one_dword;
      LW: load_data = {{32{one_word[31]}}, one_word};
      LH: load_data = {{48{one_half[15]}}, one_half};
      LB: load_data = {{56{one_byte[7]}}, one_byte};
      LWU: load_data = {32'd0, one_word};
      LHU: load_data = {48'd0, one_half};
      LBU: load_data = {56'd0, one_byte};
      // stores return nothing
      default: load_data = '0;
    endcase
  end

  // store overwrites only its own element
  always_comb begin
    merged_line = line_in;
    case (op)
      SD: merged_line.dwords[offset[offset_bits-1:3]] = store_data;
      SW: merged_line.words[offset[offset_bits-1:2]] = store_data[31:0];
      SH: merged_line.halves[offset[offset_bits-1:1]] = store_data[15:0];
      SB: merged_line.bytes[offset] = store_data[7:0];
      default: merged_line = line_in;
    endcase
  end

endmodule

// File: source/mem_op_pkg.sv
/*
  Processor memory operations and memory bus tags.
  The request struct is what the processor holds stable while req is high.
*/
package mem_op_pkg;

  // loads first, then stores
  typedef enum logic [3:0] {
    LD,
    LW,
    LH,
    LB,
    LWU,
    LHU,
    LBU,
    SD,
    SW,
    SH,
    SB
  } mem_op_t;

  // tag carried with every bus beat
  typedef enum logic [1:0] {
    tag_none,
    tag_read,
    tag_write
  } bus_tag_t;

  // one processor access, 132 bits
  typedef struct packed {
    logic [cache_geometry_pkg::address_bits-1:0] address;
    logic [cache_geometry_pkg::beat_bits-1:0] store_data;
    mem_op_t op;
  } cpu_request_t;

endpackage

// File: source/miss_controller.sv
/*
  Cache control FSM: processor req/ack handshake, lookup, write-back,
  refill, install and retry. One request is in flight at a time.
*/
`timescale 1ns/1ps

module miss_controller #(
  parameter int ways = 4,
  parameter int sets = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic req,
  input  mem_op_pkg::cpu_request_t request,
  output logic ack,
  output logic lookup,
  output logic write_line,
  output logic dirty_in,
  input  logic hit,
  input  logic victim_dirty,
  output logic start_read,
  output logic start_write,
  input  logic bus_done
);
  import cache_geometry_pkg::*;
  import mem_op_pkg::*;

  localparam int index_bits = $clog2(sets);
  localparam int refill_bits = $clog2(ways + 1);

  localparam logic [3:0] st_idle = 4'd0;
  localparam logic [3:0] st_lookup = 4'd1;
  localparam logic [3:0] st_decide = 4'd2;
  localparam logic [3:0] st_writeback = 4'd3;
  localparam logic [3:0] st_refill = 4'd4;
  localparam logic [3:0] st_install = 4'd5;
  localparam logic [3:0] st_retry = 4'd6;
  localparam logic [3:0] st_ack = 4'd7;
  localparam logic [3:0] st_release = 4'd8;

  logic [3:0] state;
  logic [index_bits-1:0] req_index;
  logic [index_bits-1:0] held_index;
  logic [refill_bits-1:0] refills;
  logic is_store;

  assign req_index = request.address[offset_bits +: index_bits];
  assign is_store = request.op inside {SD, SW, SH, SB};

  // retry is a second lookup on the freshly installed line
  assign lookup = (state == st_lookup) || (state == st_retry);
  assign ack = (state == st_ack) || (state == st_release);
  // install writes the clean bus line, a hit store writes the merged line
  assign write_line = (state == st_install) || (state == st_ack && is_store && hit);
  assign dirty_in = (state == st_ack);

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= st_idle;
      start_read <= 1'b0;
      start_write <= 1'b0;
      refills <= '0;
      held_index <= '0;
    end else begin
      start_read <= 1'b0;
      start_write <= 1'b0;
      case (state)
        st_idle: begin
          if (req) begin
            state <= st_lookup;
            held_index <= req_index;
            refills <= '0;
          end
        end
        st_lookup: state <= st_decide;
        st_decide: begin
          // set moved under a held req, look again
          if (req_index != held_index) begin
            held_index <= req_index;
            state <= st_lookup;
          end else if (hit || refills == refill_bits'(ways)) begin
            state <= st_ack;
          end else if (victim_dirty) begin
            start_write <= 1'b1;
            state <= st_writeback;
          end else begin
            start_read <= 1'b1;
            state <= st_refill;
          end
        end
        st_writeback: begin
          if (bus_done) begin
            start_read <= 1'b1;
            state <= st_refill;
          end
        end
        st_refill: if (bus_done) state <= st_install;
        st_install: begin
          refills <= refills + 1'b1;
          state <= st_retry;
        end
        st_retry: state <= st_decide;
        // ack drops on the edge that sees req low
        st_ack: state <= req ? st_release : st_idle;
        st_release: if (!req) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

endmodule
